// ==== compile.f ====
+incdir+tests
source/adc_slice_pkg.sv
source/slice_cfg_regs.sv
source/tdc_capture.sv
source/wallace_popcount.sv
source/code_accumulator.sv
source/adc_slice_backend.sv
tests/adc_slice_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the slice backend testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module adc_slice_tb \
  -f compile.f -Mdir obj_dir -o adc_slice_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/adc_slice_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides, not only the exit status
if grep -q '\*\*\* TEST PASSED \*\*\*' sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== source/adc_slice_backend.sv ====
`timescale 1ns/1ns

module adc_slice_backend #(
  parameter int nadc = 8,
  parameter int nctl = 5
) (
  input  logic                       clk_adder,
  input  logic                       rstb,
  input  adc_slice_pkg::axil_req_t   axil_req,
  output adc_slice_pkg::axil_rsp_t   axil_rsp,
  input  adc_slice_pkg::tdc_sample_t tdc_in,
  output adc_slice_pkg::adc_code_t   code_out,
  output adc_slice_pkg::acc_result_t acc_out,
  output logic [2**nctl-2:0]         thm_ctl_v2t_n,
  output logic [2**nctl-2:0]         thm_ctl_v2t_p,
  output logic [2**nctl-2:0]         thm_ctl_dcdl,
  output logic                       phase_reverse
);

  adc_slice_pkg::tdc_sample_t sample_corr;
  logic en_phase_reverse;
  logic [3:0] acc_log2;
  logic restart;
  logic [19:0] acc_sum;

  slice_cfg_regs #(.nctl(nctl)) slice_cfg_regs_i (
    .clk_adder        (clk_adder),
    .rstb             (rstb),
    .req              (axil_req),
    .rsp              (axil_rsp),
    .acc_sum          (acc_sum),
    .thm_ctl_v2t_n    (thm_ctl_v2t_n),
    .thm_ctl_v2t_p    (thm_ctl_v2t_p),
    .thm_ctl_dcdl     (thm_ctl_dcdl),
    .en_phase_reverse (en_phase_reverse),
    .acc_log2         (acc_log2),
    .restart          (restart)
  );

  tdc_capture #(.nadc(nadc)) tdc_capture_i (
    .clk_adder        (clk_adder),
    .rstb             (rstb),
    .sample_in        (tdc_in),
    .en_phase_reverse (en_phase_reverse),
    .sample_out       (sample_corr),
    .phase_reverse    (phase_reverse)
  );

  wallace_popcount #(.nadc(nadc)) wallace_popcount_i (
    .clk_adder (clk_adder),
    .rstb      (rstb),
    .sample    (sample_corr),
    .code      (code_out)
  );

  code_accumulator #(.nadc(nadc)) code_accumulator_i (
    .clk_adder (clk_adder),
    .rstb      (rstb),
    .code      (code_out),
    .acc_log2  (acc_log2),
    .restart   (restart),
    .result    (acc_out),
    .acc_sum   (acc_sum)
  );

endmodule

// ==== source/adc_slice_pkg.sv ====
package adc_slice_pkg;

  // struct widths follow these defaults, keep them equal to the top parameters
  localparam int nadc_default = 8;
  localparam int nctl_default = 5;

  localparam logic [7:0] REG_V2T    = 8'h00;
  localparam logic [7:0] REG_TDC    = 8'h04;
  localparam logic [7:0] REG_RESULT = 8'h08;

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // master side of the register port
  typedef struct packed {
    logic [7:0]  awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        rready;
  } axil_req_t;

  // slave side of the register port
  typedef struct packed {
    logic        awready;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axil_rsp_t;

  typedef struct packed {
    logic [31-2*nctl_default:0] unused;
    logic [nctl_default-1:0]    ctl_v2t_p;
    logic [nctl_default-1:0]    ctl_v2t_n;
  } v2t_fields_t;

  typedef struct packed {
    logic [26-nctl_default:0] unused;
    logic [3:0]               acc_log2;
    logic                     en_phase_reverse;
    logic [nctl_default-1:0]  ctl_dcdl;
  } tdc_fields_t;

  // config data word, meaning depends on the register address
  typedef union packed {
    v2t_fields_t v2t_view;
    tdc_fields_t tdc_view;
  } cfg_word_u;

  typedef struct packed {
    logic [2**nadc_default-2:0] ff_out;
    logic                       sign;
    logic                       valid;
  } tdc_sample_t;

  typedef struct packed {
    logic [nadc_default-1:0] mag;
    logic                    sign;
    logic                    valid;
  } adc_code_t;

  typedef struct packed {
    logic [19:0] sum;
    logic        valid;
  } acc_result_t;

endpackage

// ==== source/code_accumulator.sv ====
`timescale 1ns/1ns

module code_accumulator #(
  parameter int nadc = 8
) (
  input  logic                       clk_adder,
  input  logic                       rstb,
  input  adc_slice_pkg::adc_code_t   code,
  input  logic [3:0]                 acc_log2,
  input  logic                       restart,
  output adc_slice_pkg::acc_result_t result,
  output logic [19:0]                acc_sum
);

  logic [15:0] count;
  logic [15:0] last_idx;
  logic [19:0] mag_ext;
  logic [19:0] signed_mag;
  logic [19:0] partial;
  logic [19:0] next_sum;
  logic [19:0] held;
  logic res_valid;

  always_comb begin
    // window holds 2^acc_log2 codes
    last_idx = 16'((17'd1 << acc_log2) - 17'd1);
    mag_ext = {{(20-nadc){1'b0}}, code.mag};
    signed_mag = code.sign ? -mag_ext : mag_ext;
    next_sum = partial + signed_mag;
  end

  always_ff @(posedge clk_adder or negedge rstb) begin
    if (!rstb) begin
      count <= '0;
      partial <= '0;
      held <= '0;
      res_valid <= 1'b0;
    end else begin
      res_valid <= 1'b0;
      if (restart) begin
        count <= '0;
        partial <= '0;
      end else if (code.valid) begin
        if (count == last_idx) begin
          held <= next_sum;
          res_valid <= 1'b1;
          count <= '0;
          partial <= '0;
        end else begin
          partial <= next_sum;
          count <= count + 16'd1;
        end
      end
    end
  end

  assign acc_sum = held;

  always_comb begin
    result.sum = held;
    result.valid = res_valid;
  end

endmodule

// ==== source/slice_cfg_regs.sv ====
`timescale 1ns/1ns

module slice_cfg_regs #(
  parameter int nctl = 5
) (
  input  logic                     clk_adder,
  input  logic                     rstb,
  input  adc_slice_pkg::axil_req_t req,
  output adc_slice_pkg::axil_rsp_t rsp,
  input  logic [19:0]              acc_sum,
  output logic [2**nctl-2:0]       thm_ctl_v2t_n,
  output logic [2**nctl-2:0]       thm_ctl_v2t_p,
  output logic [2**nctl-2:0]       thm_ctl_dcdl,
  output logic                     en_phase_reverse,
  output logic [3:0]               acc_log2,
  output logic                     restart
);

  logic [nctl-1:0] ctl_v2t_n;
  logic [nctl-1:0] ctl_v2t_p;
  logic [nctl-1:0] ctl_dcdl;
  logic aw_held;
  logic w_held;
  logic [7:0] aw_addr_q;
  logic [31:0] w_data_q;
  logic [3:0] w_strb_q;
  logic bvalid;
  logic rvalid;
  logic [1:0] bresp;
  logic [1:0] rresp;
  logic [31:0] rdata;
  logic aw_hs;
  logic w_hs;
  logic ar_hs;
  logic do_write;
  logic [7:0] wr_addr;
  logic [31:0] wr_data;
  logic [3:0] wr_strb;
  logic [31:0] merged;
  adc_slice_pkg::cfg_word_u cur_word;
  adc_slice_pkg::cfg_word_u wr_word;

  // register contents as seen on the bus
  function automatic adc_slice_pkg::cfg_word_u reg_word(input logic [7:0] addr);
    adc_slice_pkg::cfg_word_u w;
    w = '0;
    case (addr)
      adc_slice_pkg::REG_V2T: begin
        w.v2t_view.ctl_v2t_n = ctl_v2t_n;
        w.v2t_view.ctl_v2t_p = ctl_v2t_p;
      end
      adc_slice_pkg::REG_TDC: begin
        w.tdc_view.ctl_dcdl = ctl_dcdl;
        w.tdc_view.en_phase_reverse = en_phase_reverse;
        w.tdc_view.acc_log2 = acc_log2;
      end
      adc_slice_pkg::REG_RESULT: w = {{12{acc_sum[19]}}, acc_sum};
      default: w = '0;
    endcase
    return w;
  endfunction

  assign aw_hs = req.awvalid && !aw_held && !bvalid;
  assign w_hs = req.wvalid && !w_held && !bvalid;
  assign ar_hs = req.arvalid && !rvalid;
  assign do_write = (aw_held || aw_hs) && (w_held || w_hs);
  assign restart = do_write && (wr_addr == adc_slice_pkg::REG_TDC);

  // byte strobes merge new data over the current contents
  always_comb begin
    wr_addr = aw_held ? aw_addr_q : req.awaddr;
    wr_data = w_held ? w_data_q : req.wdata;
    wr_strb = w_held ? w_strb_q : req.wstrb;
    cur_word = reg_word(wr_addr);
    for (int b = 0; b < 4; b++) begin
      merged[8*b +: 8] = wr_strb[b] ? wr_data[8*b +: 8] : cur_word[8*b +: 8];
    end
    wr_word = merged;
  end

  always_ff @(posedge clk_adder) begin
    if (aw_hs) aw_addr_q <= req.awaddr;
    if (w_hs) begin
      w_data_q <= req.wdata;
      w_strb_q <= req.wstrb;
    end
    if (ar_hs) rdata <= reg_word(req.araddr);
  end

  always_ff @(posedge clk_adder or negedge rstb) begin
    if (!rstb) begin
      aw_held <= 1'b0;
      w_held <= 1'b0;
      bvalid <= 1'b0;
      bresp <= adc_slice_pkg::RESP_OKAY;
      rvalid <= 1'b0;
      rresp <= adc_slice_pkg::RESP_OKAY;
      ctl_v2t_n <= '0;
      ctl_v2t_p <= '0;
      ctl_dcdl <= '0;
      en_phase_reverse <= 1'b0;
      acc_log2 <= '0;
    end else begin
      if (do_write) begin
        aw_held <= 1'b0;
        w_held <= 1'b0;
        bvalid <= 1'b1;
        case (wr_addr)
          adc_slice_pkg::REG_V2T: begin
            ctl_v2t_n <= wr_word.v2t_view.ctl_v2t_n;
            ctl_v2t_p <= wr_word.v2t_view.ctl_v2t_p;
            bresp <= adc_slice_pkg::RESP_OKAY;
          end
          adc_slice_pkg::REG_TDC: begin
            ctl_dcdl <= wr_word.tdc_view.ctl_dcdl;
            en_phase_reverse <= wr_word.tdc_view.en_phase_reverse;
            acc_log2 <= wr_word.tdc_view.acc_log2;
            bresp <= adc_slice_pkg::RESP_OKAY;
          end
          // result register is read only
          default: bresp <= adc_slice_pkg::RESP_SLVERR;
        endcase
      end else begin
        if (aw_hs) aw_held <= 1'b1;
        if (w_hs) w_held <= 1'b1;
        if (bvalid && req.bready) bvalid <= 1'b0;
      end
      if (ar_hs) begin
        rvalid <= 1'b1;
        if (req.araddr == adc_slice_pkg::REG_V2T || req.araddr == adc_slice_pkg::REG_TDC ||
            req.araddr == adc_slice_pkg::REG_RESULT) begin
          rresp <= adc_slice_pkg::RESP_OKAY;
        end else begin
          rresp <= adc_slice_pkg::RESP_SLVERR;
        end
      end else if (rvalid && req.rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_comb begin
    rsp.awready = !aw_held && !bvalid;
    rsp.wready = !w_held && !bvalid;
    rsp.bresp = bresp;
    rsp.bvalid = bvalid;
    rsp.arready = !rvalid;
    rsp.rdata = rdata;
    rsp.rresp = rresp;
    rsp.rvalid = rvalid;
  end

  // binary trim v sets the low v bits
  always_comb begin
    for (int i = 0; i < 2**nctl-1; i++) begin
      thm_ctl_v2t_n[i] = (i < ctl_v2t_n);
      thm_ctl_v2t_p[i] = (i < ctl_v2t_p);
      thm_ctl_dcdl[i] = (i < ctl_dcdl);
    end
  end

endmodule

// ==== source/tdc_capture.sv ====
`timescale 1ns/1ns

module tdc_capture #(
  parameter int nadc = 8
) (
  input  logic                       clk_adder,
  input  logic                       rstb,
  input  adc_slice_pkg::tdc_sample_t sample_in,
  input  logic                       en_phase_reverse,
  output adc_slice_pkg::tdc_sample_t sample_out,
  output logic                       phase_reverse
);

  localparam int nbit = 2**nadc - 1;

  logic [nbit+1:0] ext;
  logic [nbit-1:0] corrected;
  logic [nbit-1:0] ff_q;
  logic sign_q;
  logic valid_q;
  logic pr_sampled;

  // padded word, a one below bit 0 and a zero above the top bit
  assign ext = {1'b0, sample_in.ff_out, 1'b1};

  // three input majority removes single bubbles
  always_comb begin
    for (int i = 0; i < nbit; i++) begin
      corrected[i] = (ext[i] & ext[i+1]) | (ext[i] & ext[i+2]) | (ext[i+1] & ext[i+2]);
    end
  end

  always_ff @(posedge clk_adder) begin
    ff_q <= corrected;
    sign_q <= sample_in.sign;
  end

  always_ff @(posedge clk_adder or negedge rstb) begin
    if (!rstb) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= sample_in.valid;
    end
  end

  // two flop synchronizer for the phase reverse enable
  always_ff @(posedge clk_adder or negedge rstb) begin
    if (!rstb) begin
      pr_sampled <= 1'b0;
      phase_reverse <= 1'b0;
    end else begin
      pr_sampled <= en_phase_reverse;
      phase_reverse <= pr_sampled;
    end
  end

  always_comb begin
    sample_out.ff_out = ff_q;
    sample_out.sign = sign_q;
    sample_out.valid = valid_q;
  end

endmodule

// ==== source/wallace_popcount.sv ====
`timescale 1ns/1ns

module wallace_popcount #(
  parameter int nadc = 8
) (
  input  logic                       clk_adder,
  input  logic                       rstb,
  input  adc_slice_pkg::tdc_sample_t sample,
  output adc_slice_pkg::adc_code_t   code
);

  localparam int nbit = 2**nadc - 1;
  localparam int gw = 16;
  localparam int ngrp = (nbit + gw - 1) / gw;
  localparam int cw = $clog2(gw + 1);

  logic [ngrp*gw-1:0] padded;
  logic [cw-1:0] grp_cnt [ngrp];
  logic [cw-1:0] grp_q [ngrp];
  logic s1_sign;
  logic s1_valid;
  logic [nadc-1:0] total;
  logic [nadc-1:0] mag_q;
  logic sign_q;
  logic valid_q;

  // stage one, ones count per 16 bit group
  always_comb begin
    padded = '0;
    padded[nbit-1:0] = sample.ff_out;
    for (int g = 0; g < ngrp; g++) begin
      grp_cnt[g] = '0;
      for (int b = 0; b < gw; b++) begin
        grp_cnt[g] = grp_cnt[g] + cw'(padded[g*gw+b]);
      end
    end
  end

  always_ff @(posedge clk_adder) begin
    for (int g = 0; g < ngrp; g++) begin
      grp_q[g] <= grp_cnt[g];
    end
    s1_sign <= sample.sign;
  end

  // stage two, sum of the partial counts
  always_comb begin
    total = '0;
    for (int g = 0; g < ngrp; g++) begin
      total = total + nadc'(grp_q[g]);
    end
  end

  always_ff @(posedge clk_adder) begin
    mag_q <= total;
    sign_q <= s1_sign;
  end

  always_ff @(posedge clk_adder or negedge rstb) begin
    if (!rstb) begin
      s1_valid <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      s1_valid <= sample.valid;
      valid_q <= s1_valid;
    end
  end

  always_comb begin
    code.mag = mag_q;
    code.sign = sign_q;
    code.valid = valid_q;
  end

endmodule

// ==== tests/adc_slice_tb_tasks.svh ====
`ifndef ADC_SLICE_TB_TASKS_SVH
`define ADC_SLICE_TB_TASKS_SVH

task automatic stop_on_error(input string why);
  errors++;
  $display("%s", why);
  $display("*** TEST FAILED ***");
  $fatal(1, "stopped at first error");
endtask

// data fields only matter when a valid code is expected
task automatic check_code(input string name, input adc_slice_pkg::adc_code_t got,
                          input adc_slice_pkg::adc_code_t exp);
  if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
    stop_on_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
  end
endtask

task automatic check_acc(input string name, input adc_slice_pkg::acc_result_t got,
                         input adc_slice_pkg::acc_result_t exp);
  if (got.valid !== exp.valid || (exp.valid && got.sum !== exp.sum)) begin
    stop_on_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
  end
endtask

task automatic check_rsp(input string name, input logic [31:0] got_data,
                         input logic [1:0] got_resp, input logic [31:0] exp_data,
                         input logic [1:0] exp_resp);
  if (got_resp !== exp_resp) begin
    stop_on_error($sformatf("FAIL %s resp: got %h, expected %h", name, got_resp, exp_resp));
  end
  if (got_data !== exp_data) begin
    stop_on_error($sformatf("FAIL %s data: got %h, expected %h", name, got_data, exp_data));
  end
endtask

task automatic check_thm(input string name, input logic [ntrim-1:0] got,
                         input logic [ntrim-1:0] exp);
  if (got !== exp) begin
    stop_on_error($sformatf("FAIL %s: got %h, expected %h", name, got, exp));
  end
endtask

// returns one falling edge after the write response was taken
task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
  int waited;
  logic aw_open;
  logic w_open;
  logic aw_rdy;
  logic w_rdy;
  @(negedge clk_adder);
  axil_req.awaddr = addr;
  axil_req.awvalid = 1'b1;
  axil_req.wdata = data;
  axil_req.wstrb = 4'hf;
  axil_req.wvalid = 1'b1;
  axil_req.bready = 1'b1;
  aw_open = 1'b1;
  w_open = 1'b1;
  waited = 0;
  while (aw_open || w_open) begin
    aw_rdy = axil_rsp.awready;
    w_rdy = axil_rsp.wready;
    @(negedge clk_adder);
    if (aw_open && aw_rdy) begin
      aw_open = 1'b0;
      axil_req.awvalid = 1'b0;
    end
    if (w_open && w_rdy) begin
      w_open = 1'b0;
      axil_req.wvalid = 1'b0;
    end
    waited++;
    if (waited > timeout_cycles) stop_on_error("write address or data was never accepted");
  end
  waited = 0;
  while (!axil_rsp.bvalid) begin
    @(negedge clk_adder);
    waited++;
    if (waited > timeout_cycles) stop_on_error("write response never arrived");
  end
  resp = axil_rsp.bresp;
  @(negedge clk_adder);
  axil_req.bready = 1'b0;
endtask

task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
  int waited;
  logic ar_rdy;
  @(negedge clk_adder);
  axil_req.araddr = addr;
  axil_req.arvalid = 1'b1;
  axil_req.rready = 1'b1;
  waited = 0;
  while (axil_req.arvalid) begin
    ar_rdy = axil_rsp.arready;
    @(negedge clk_adder);
    if (ar_rdy) axil_req.arvalid = 1'b0;
    waited++;
    if (waited > timeout_cycles) stop_on_error("read address was never accepted");
  end
  waited = 0;
  while (!axil_rsp.rvalid) begin
    @(negedge clk_adder);
    waited++;
    if (waited > timeout_cycles) stop_on_error("read data never arrived");
  end
  data = axil_rsp.rdata;
  resp = axil_rsp.rresp;
  @(negedge clk_adder);
  axil_req.rready = 1'b0;
endtask

task automatic step_sample(input logic [nbit-1:0] word, input logic sign, input logic valid);
  @(negedge clk_adder);
  tdc_in.ff_out = word;
  tdc_in.sign = sign;
  tdc_in.valid = valid;
endtask

task automatic reset_state();
  logic [31:0] rdata;
  logic [1:0] resp;
  axil_read(adc_slice_pkg::REG_V2T, rdata, resp);
  check_rsp("reset REG_V2T", rdata, resp, 32'h0, adc_slice_pkg::RESP_OKAY);
  axil_read(adc_slice_pkg::REG_TDC, rdata, resp);
  check_rsp("reset REG_TDC", rdata, resp, 32'h0, adc_slice_pkg::RESP_OKAY);
  axil_read(adc_slice_pkg::REG_RESULT, rdata, resp);
  check_rsp("reset REG_RESULT", rdata, resp, 32'h0, adc_slice_pkg::RESP_OKAY);
  check_thm("thm_ctl_v2t_n", thm_ctl_v2t_n, '0);
  check_thm("thm_ctl_v2t_p", thm_ctl_v2t_p, '0);
  check_thm("thm_ctl_dcdl", thm_ctl_dcdl, '0);
  check_code("code_out", code_out, '0);
  check_acc("acc_out", acc_out, '0);
  if (phase_reverse !== 1'b0) begin
    stop_on_error($sformatf("FAIL phase_reverse: got %h, expected %h", phase_reverse, 1'b0));
  end
endtask

task automatic trim_writes();
  logic [nctl-1:0] v2t_n;
  logic [nctl-1:0] v2t_p;
  logic [nctl-1:0] dcdl;
  logic [3:0] log2;
  logic [31:0] word;
  logic [31:0] rdata;
  logic [1:0] resp;
  v2t_n = nctl'($urandom());
  v2t_p = nctl'($urandom());
  dcdl = nctl'($urandom());
  log2 = 4'($urandom());
  word = 32'({v2t_p, v2t_n});
  axil_write(adc_slice_pkg::REG_V2T, word, resp);
  check_rsp("write REG_V2T", 32'h0, resp, 32'h0, adc_slice_pkg::RESP_OKAY);
  check_thm("thm_ctl_v2t_n", thm_ctl_v2t_n, trim_thermo(v2t_n));
  check_thm("thm_ctl_v2t_p", thm_ctl_v2t_p, trim_thermo(v2t_p));
  axil_read(adc_slice_pkg::REG_V2T, rdata, resp);
  check_rsp("read REG_V2T", rdata, resp, word, adc_slice_pkg::RESP_OKAY);
  word = 32'({log2, 1'b1, dcdl});
  axil_write(adc_slice_pkg::REG_TDC, word, resp);
  check_rsp("write REG_TDC", 32'h0, resp, 32'h0, adc_slice_pkg::RESP_OKAY);
  // only the first flop has switched one edge after the commit
  if (phase_reverse !== 1'b0) begin
    stop_on_error($sformatf("FAIL phase_reverse: got %h, expected %h", phase_reverse, 1'b0));
  end
  @(negedge clk_adder);
  if (phase_reverse !== 1'b1) begin
    stop_on_error($sformatf("FAIL phase_reverse: got %h, expected %h", phase_reverse, 1'b1));
  end
  check_thm("thm_ctl_dcdl", thm_ctl_dcdl, trim_thermo(dcdl));
  axil_read(adc_slice_pkg::REG_TDC, rdata, resp);
  check_rsp("read REG_TDC", rdata, resp, word, adc_slice_pkg::RESP_OKAY);
endtask

task automatic popcount_stream();
  int fill [stream_len];
  logic sgn [stream_len];
  adc_slice_pkg::adc_code_t exp;
  for (int i = 0; i < stream_len; i++) begin
    fill[i] = (i == 0) ? 0 : (i == 1) ? nbit : int'($urandom_range(0, nbit));
    sgn[i] = 1'($urandom_range(0, 1));
  end
  for (int c = 0; c < stream_len + 3; c++) begin
    if (c < stream_len) step_sample(clean_word(fill[c]), sgn[c], 1'b1);
    else step_sample('0, 1'b0, 1'b0);
    exp = '0;
    if (c >= 3) begin
      exp.mag = nadc'(fill[c-3]);
      exp.sign = sgn[c-3];
      exp.valid = 1'b1;
    end
    check_code("code_out", code_out, exp);
  end
endtask

task automatic bubble_fix();
  int fill;
  int pos;
  logic [nbit-1:0] word;
  logic sgn;
  adc_slice_pkg::adc_code_t exp;
  for (int k = 0; k < 6; k++) begin
    fill = $urandom_range(3, nbit - 3);
    word = clean_word(fill);
    // hole well inside the ones or a stray one clear of their edge
    if (k % 2 == 0) pos = $urandom_range(0, fill - 3);
    else pos = $urandom_range(fill + 2, nbit - 1);
    word[pos] = ~word[pos];
    sgn = 1'($urandom_range(0, 1));
    step_sample(word, sgn, 1'b1);
    repeat (3) step_sample('0, 1'b0, 1'b0);
    exp.mag = nadc'(fill);
    exp.sign = sgn;
    exp.valid = 1'b1;
    check_code("code_out bubble", code_out, exp);
  end
endtask

task automatic window_sum();
  int total;
  int fill;
  int waited;
  logic sgn;
  logic [31:0] rdata;
  logic [1:0] resp;
  adc_slice_pkg::acc_result_t exp;
  // acc_log2 = 3 in bits 9:6
  axil_write(adc_slice_pkg::REG_TDC, 32'h0000_00c0, resp);
  check_rsp("write REG_TDC", 32'h0, resp, 32'h0, adc_slice_pkg::RESP_OKAY);
  total = 0;
  for (int i = 0; i < window_len; i++) begin
    fill = $urandom_range(0, nbit);
    sgn = 1'($urandom_range(0, 1));
    total = sgn ? total - fill : total + fill;
    step_sample(clean_word(fill), sgn, 1'b1);
  end
  waited = 0;
  while (!acc_out.valid) begin
    step_sample('0, 1'b0, 1'b0);
    waited++;
    if (waited > timeout_cycles) stop_on_error("window result never became valid");
  end
  exp.sum = 20'(total);
  exp.valid = 1'b1;
  check_acc("acc_out", acc_out, exp);
  step_sample('0, 1'b0, 1'b0);
  check_acc("acc_out after pulse", acc_out, '0);
  last_total = total;
  axil_read(adc_slice_pkg::REG_RESULT, rdata, resp);
  check_rsp("read REG_RESULT", rdata, resp, 32'(total), adc_slice_pkg::RESP_OKAY);
endtask

task automatic address_errors();
  logic [31:0] rdata;
  logic [1:0] resp;
  axil_read(8'h0c, rdata, resp);
  check_rsp("read unknown", rdata, resp, 32'h0, adc_slice_pkg::RESP_SLVERR);
  axil_write(adc_slice_pkg::REG_RESULT, $urandom(), resp);
  check_rsp("write REG_RESULT", 32'h0, resp, 32'h0, adc_slice_pkg::RESP_SLVERR);
  axil_read(adc_slice_pkg::REG_RESULT, rdata, resp);
  check_rsp("held sum", rdata, resp, 32'(last_total), adc_slice_pkg::RESP_OKAY);
endtask

`endif

// ==== tests/adc_slice_tb.sv ====
`timescale 1ns/1ns

module adc_slice_tb;

  localparam int nadc = adc_slice_pkg::nadc_default;
  localparam int nctl = adc_slice_pkg::nctl_default;
  localparam int nbit = 2**nadc - 1;
  localparam int ntrim = 2**nctl - 1;
  localparam int timeout_cycles = 50;
  localparam int stream_len = 24;
  localparam int window_len = 8;

  logic clk_adder;
  logic rstb;
  adc_slice_pkg::axil_req_t axil_req;
  adc_slice_pkg::axil_rsp_t axil_rsp;
  adc_slice_pkg::tdc_sample_t tdc_in;
  adc_slice_pkg::adc_code_t code_out;
  adc_slice_pkg::acc_result_t acc_out;
  logic [ntrim-1:0] thm_ctl_v2t_n;
  logic [ntrim-1:0] thm_ctl_v2t_p;
  logic [ntrim-1:0] thm_ctl_dcdl;
  logic phase_reverse;
  int errors;
  // signed total of the last completed window
  int last_total;

  adc_slice_backend #(.nadc(nadc), .nctl(nctl)) adc_slice_backend_i (
    .clk_adder     (clk_adder),
    .rstb          (rstb),
    .axil_req      (axil_req),
    .axil_rsp      (axil_rsp),
    .tdc_in        (tdc_in),
    .code_out      (code_out),
    .acc_out       (acc_out),
    .thm_ctl_v2t_n (thm_ctl_v2t_n),
    .thm_ctl_v2t_p (thm_ctl_v2t_p),
    .thm_ctl_dcdl  (thm_ctl_dcdl),
    .phase_reverse (phase_reverse)
  );

  initial begin
    clk_adder = 1'b0;
    forever #20 clk_adder = ~clk_adder;
  end

  // tdc word with the low fill bits set
  function automatic logic [nbit-1:0] clean_word(input int fill);
    logic [nbit-1:0] w;
    for (int i = 0; i < nbit; i++) begin
      w[i] = (i < fill);
    end
    return w;
  endfunction

  // expected trim thermometer for binary value v
  function automatic logic [ntrim-1:0] trim_thermo(input int v);
    return ntrim'((32'd1 << v) - 32'd1);
  endfunction

  `include "adc_slice_tb_tasks.svh"

  initial begin
    errors = 0;
    last_total = 0;
    void'($urandom(32'hfbd32733));
    rstb = 1'b0;
    axil_req = '0;
    tdc_in = '0;
    repeat (5) @(posedge clk_adder);
    @(negedge clk_adder);
    rstb = 1'b1;

    reset_state();
    trim_writes();
    popcount_stream();
    bubble_fix();
    window_sum();
    address_errors();

    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
